// ==== common/ecpu_pkg.sv ====
package ecpu_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int DWIDTH    = 16;
  localparam int OPWIDTH   = 4;
  localparam int AWIDTH    = 10;
  localparam int ROM_DEPTH = 1024;

  typedef logic [DWIDTH-1:0]  data_t;
  typedef logic [AWIDTH-1:0]  addr_t;
  typedef logic [OPWIDTH-1:0] alu_op_t;

  ////////////////////
  // instruction words
  ////////////////////

  // starts an ALU instruction, followed by A, B and S
  localparam data_t OP_ALU  = 16'd7;
  localparam data_t OP_HALT = 16'h0080;

  // alu operation codes, anything above ALU_PASSA yields zero
  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_AND   = 4'd2;
  localparam alu_op_t ALU_OR    = 4'd3;
  localparam alu_op_t ALU_XOR   = 4'd4;
  localparam alu_op_t ALU_SHL   = 4'd5;
  localparam alu_op_t ALU_SHR   = 4'd6;
  localparam alu_op_t ALU_PASSA = 4'd7;

  ////////////////////
  // controller
  ////////////////////

  typedef enum logic [2:0] {
    IDLE,
    INSTR_FETCH,
    INSTR_DECODE,
    OPERAND_FETCH,
    EXECUTE,
    HALT_CPU
  } ctrl_state_t;

  // what the accumulator currently shows
  typedef enum logic [0:0] {
    ROM_OUT,
    ALU_OUT
  } acc_src_t;

  typedef struct packed {
    data_t y;
    logic  c;
    logic  v;
    logic  z;
  } alu_result_t;

  typedef struct packed {
    data_t   a;
    data_t   b;
    alu_op_t s;
  } alu_req_t;

endpackage

// ==== design/ecpu_rom.sv ====
`timescale 1ns/1ns

module ecpu_rom (
  input  logic            CLK,
  input  logic            load_en,
  input  ecpu_pkg::addr_t load_addr,
  input  ecpu_pkg::data_t load_data,
  input  logic            rom_rd,
  input  ecpu_pkg::addr_t rom_addr,
  output ecpu_pkg::data_t rom_data
);

  import ecpu_pkg::*;

  data_t mem [ROM_DEPTH];

  // program load while the core sits idle
  always_ff @(posedge CLK)
  begin
    if (load_en)
      mem[load_addr] <= load_data;
  end

  // registered read, output holds between reads
  always_ff @(posedge CLK)
  begin
    if (rom_rd)
      rom_data <= mem[rom_addr];
  end

endmodule

// ==== design/ecpu_top.sv ====
`timescale 1ns/1ns

module ecpu_top (
  input  logic                  CLK,
  input  logic                  RESET_N,
  input  logic                  start,
  input  logic                  load_en,
  input  ecpu_pkg::addr_t       load_addr,
  input  ecpu_pkg::data_t       load_data,
  output ecpu_pkg::alu_result_t result,
  output logic                  result_valid,
  output ecpu_pkg::acc_src_t    acc_src,
  output logic                  halted
);

  import ecpu_pkg::*;

  logic        rom_rd;
  addr_t       rom_addr;
  data_t       rom_data;
  alu_req_t    alu_req;
  alu_result_t alu_result;

  ecpu_core_controller ctrl0 (
    .CLK          (CLK),
    .RESET_N      (RESET_N),
    .start        (start),
    .load_en      (load_en),
    .rom_rd       (rom_rd),
    .rom_addr     (rom_addr),
    .rom_data     (rom_data),
    .alu_req      (alu_req),
    .alu_result   (alu_result),
    .result       (result),
    .result_valid (result_valid),
    .acc_src      (acc_src),
    .halted       (halted)
  );

  ecpu_alu alu0 (
    .alu_req    (alu_req),
    .alu_result (alu_result)
  );

  ecpu_rom rom0 (
    .CLK       (CLK),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rom_rd    (rom_rd),
    .rom_addr  (rom_addr),
    .rom_data  (rom_data)
  );

endmodule

// ==== dv/ecpu_tb.sv ====
`timescale 1ns/1ns

module ecpu_tb;

  import ecpu_pkg::*;

  localparam int CLK_HALF   = 4;
  localparam int N_ROWS     = 30;
  localparam int RUN1_FIRST = 0;
  localparam int RUN1_LAST  = 25;
  localparam int RUN2_FIRST = 26;
  localparam int RUN2_LAST  = 29;
  localparam int WD_NS      = 2 * CLK_HALF * (N_ROWS * 6 + ROM_DEPTH * 2 + 200);

  typedef enum logic [1:0] {ROW_NOP, ROW_ALU, ROW_HALT} row_kind_t;
  typedef logic [4:0] row_idx_t;

  // a no-op row places its a field as the instruction word
  typedef struct packed {
    row_kind_t kind;
    data_t     a;
    data_t     b;
    alu_op_t   s;
  } row_t;

  logic        CLK;
  logic        RESET_N;
  logic        start;
  logic        load_en;
  addr_t       load_addr;
  data_t       load_data;
  alu_result_t result;
  logic        result_valid;
  acc_src_t    acc_src;
  logic        halted;

  row_t        rows [N_ROWS];
  data_t       image [ROM_DEPTH];
  alu_result_t expect_q [$];
  time         run_start;
  logic        seen_result;
  int          result_idx = 0;

  ecpu_top dut0 (
    .CLK          (CLK),
    .RESET_N      (RESET_N),
    .start        (start),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .result       (result),
    .result_valid (result_valid),
    .acc_src      (acc_src),
    .halted       (halted)
  );

  initial
  begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  ////////////////////
  // reference and checks
  ////////////////////

  function automatic alu_result_t alu_model(input data_t a, input data_t b, input alu_op_t s);
    alu_result_t r;
    int          ua;
    int          ub;
    int          full;
    r    = '0;
    ua   = int'(a);
    ub   = int'(b);
    full = 0;
    case (s)
      ALU_ADD:
      begin
        r.y  = a + b;
        r.c  = (ua + ub) > 65535;
        full = int'($signed(a)) + int'($signed(b));
      end
      ALU_SUB:
      begin
        r.y  = a - b;
        // no borrow means a carry out of a + ~b + 1
        r.c  = (ua >= ub);
        full = int'($signed(a)) - int'($signed(b));
      end
      ALU_AND:   r.y = a & b;
      ALU_OR:    r.y = a | b;
      ALU_XOR:   r.y = a ^ b;
      ALU_SHL:   r.y = a << 1;
      ALU_SHR:   r.y = a >> 1;
      ALU_PASSA: r.y = a;
      default:   r.y = '0;
    endcase
    // signed result outside the 16-bit range
    r.v = (full > 32767) || (full < -32768);
    if (s <= ALU_PASSA)
      r.z = (r.y == '0);
    return r;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("Checks failed");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_result(input alu_result_t act, input alu_result_t exp, input int idx);
    if (act !== exp)
    begin
      $display("ERROR at %0t: result %0d got y=%h c=%b v=%b z=%b, expected y=%h c=%b v=%b z=%b",
               $time, idx, act.y, act.c, act.v, act.z, exp.y, exp.c, exp.v, exp.z);
      stop_with_error("result mismatch");
    end
  endtask

  task automatic check_src(input acc_src_t act, input acc_src_t exp, input string what);
    if (act !== exp)
    begin
      $display("ERROR at %0t: %s got %s expected %s", $time, what, act.name(), exp.name());
      stop_with_error("accumulator source mismatch");
    end
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp)
    begin
      $display("ERROR at %0t: %s got %b expected %b", $time, what, act, exp);
      stop_with_error("flag mismatch");
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic step_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic apply_reset();
    RESET_N = 1'b0;
    repeat (10)
      @(posedge CLK);
    #1;
    RESET_N = 1'b1;
  endtask

  task automatic fill_table();
    rows[0]  = '{ROW_ALU, 16'h1234, 16'h0001, ALU_ADD};
    rows[1]  = '{ROW_NOP, 16'h0000, 16'h0000, '0};
    // carry out with a zero sum, then signed overflow
    rows[2]  = '{ROW_ALU, 16'hffff, 16'h0001, ALU_ADD};
    rows[3]  = '{ROW_ALU, 16'h7fff, 16'h0001, ALU_ADD};
    rows[4]  = '{ROW_ALU, 16'h0005, 16'h0005, ALU_SUB};
    rows[5]  = '{ROW_NOP, 16'h1234, 16'h0000, '0};
    rows[6]  = '{ROW_ALU, 16'h8000, 16'h0001, ALU_SUB};
    rows[7]  = '{ROW_ALU, 16'h0001, 16'h0002, ALU_SUB};
    rows[8]  = '{ROW_ALU, 16'hf0f0, 16'h3c3c, ALU_AND};
    rows[9]  = '{ROW_ALU, 16'h0f00, 16'h00f0, ALU_OR};
    rows[10] = '{ROW_ALU, 16'ha5a5, 16'ha5a5, ALU_XOR};
    rows[11] = '{ROW_NOP, 16'h0081, 16'h0000, '0};
    rows[12] = '{ROW_ALU, 16'h8001, 16'h0000, ALU_SHL};
    rows[13] = '{ROW_ALU, 16'h8001, 16'h0000, ALU_SHR};
    rows[14] = '{ROW_ALU, 16'hbeef, 16'h0000, ALU_PASSA};
    // unused codes
    rows[15] = '{ROW_ALU, 16'h1234, 16'h5678, 4'd9};
    rows[16] = '{ROW_ALU, 16'hffff, 16'hffff, 4'd15};
    for (int i = 17; i <= 22; i++)
      rows[row_idx_t'(i)] = '{ROW_ALU, data_t'($urandom), data_t'($urandom), alu_op_t'(i - 16)};
    rows[23] = '{ROW_HALT, 16'h0000, 16'h0000, '0};
    // never executed
    rows[24] = '{ROW_ALU, 16'h0001, 16'h0001, ALU_ADD};
    rows[25] = '{ROW_NOP, 16'h0006, 16'h0000, '0};
    // second run at the top of the rom
    rows[26] = '{ROW_ALU, 16'h1234, 16'h00ff, ALU_XOR};
    rows[27] = '{ROW_NOP, 16'h0100, 16'h0000, '0};
    rows[28] = '{ROW_NOP, 16'h0008, 16'h0000, '0};
    rows[29] = '{ROW_ALU, 16'h8000, 16'h8000, ALU_ADD};
  endtask

  task automatic load_program(input int first, input int last, input logic at_end);
    int   words;
    int   addr;
    logic halt_seen;
    row_t row;
    words = 0;
    for (int r = first; r <= last; r++)
      words += (rows[row_idx_t'(r)].kind == ROW_ALU) ? 4 : 1;
    addr      = at_end ? ROM_DEPTH - words : 0;
    halt_seen = 1'b0;
    for (int i = 0; i < ROM_DEPTH; i++)
      image[addr_t'(i)] = '0;
    for (int r = first; r <= last; r++)
    begin
      row = rows[row_idx_t'(r)];
      case (row.kind)
        ROW_ALU:
        begin
          image[addr_t'(addr)]     = OP_ALU;
          image[addr_t'(addr + 1)] = row.a;
          image[addr_t'(addr + 2)] = row.b;
          image[addr_t'(addr + 3)] = data_t'(row.s);
          addr += 4;
          if (!halt_seen)
            expect_q.push_back(alu_model(row.a, row.b, row.s));
        end
        ROW_HALT:
        begin
          image[addr_t'(addr)] = OP_HALT;
          addr += 1;
          halt_seen = 1'b1;
        end
        default:
        begin
          image[addr_t'(addr)] = row.a;
          addr += 1;
        end
      endcase
    end
    for (int i = 0; i < ROM_DEPTH; i++)
    begin
      load_en   = 1'b1;
      load_addr = addr_t'(i);
      load_data = image[addr_t'(i)];
      step_cycle();
    end
    load_en = 1'b0;
  endtask

  task automatic check_idle_outputs();
    check_flag(result_valid, 1'b0, "result_valid before start");
    check_flag(halted, 1'b0, "halted before start");
    check_src(acc_src, ROM_OUT, "acc_src before start");
  endtask

  task automatic pulse_start();
    run_start = $time;
    start     = 1'b1;
    step_cycle();
    start     = 1'b0;
  endtask

  task automatic run_to_halt();
    pulse_start();
    while (!halted)
      step_cycle();
    // a pulse may share the cycle in which halted rises
    repeat (10)
      step_cycle();
  endtask

  ////////////////////
  // monitor and watchdog
  ////////////////////

  always @(negedge CLK)
  begin
    if (!RESET_N)
    begin
      seen_result = 1'b0;
    end
    else
    begin
      if (result_valid)
      begin
        if (expect_q.size() == 0)
        begin
          $display("ERROR at %0t: result pulse with no ALU instruction pending", $time);
          stop_with_error("unexpected result pulse");
        end
        else
        begin
          check_result(result, expect_q.pop_front(), result_idx);
          result_idx++;
          seen_result = 1'b1;
        end
      end
      check_src(acc_src, seen_result ? ALU_OUT : ROM_OUT, "acc_src");
    end
  end

  initial
  begin
    forever
    begin
      @(posedge CLK);
      if (($time - run_start) > time'(WD_NS))
        stop_with_error("timeout: core never halted");
    end
  end

  initial
  begin
    void'($urandom(32'hf4c0_14bb));
    RESET_N   = 1'b0;
    start     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    run_start = 0;
    fill_table();
    apply_reset();
    load_program(RUN1_FIRST, RUN1_LAST, 1'b0);
    check_idle_outputs();
    run_to_halt();
    check_flag(expect_q.size() == 0, 1'b1, "all first run results seen");
    // halted core ignores another start
    pulse_start();
    repeat (20)
      step_cycle();
    check_flag(halted, 1'b1, "halted after a second start");
    apply_reset();
    load_program(RUN2_FIRST, RUN2_LAST, 1'b1);
    check_idle_outputs();
    run_to_halt();
    check_flag(expect_q.size() == 0, 1'b1, "all second run results seen");
    check_flag(halted, 1'b1, "halted after the last rom word");
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== ecpu_core/ecpu_alu.sv ====
`timescale 1ns/1ns

module ecpu_alu (
  input  ecpu_pkg::alu_req_t    alu_req,
  output ecpu_pkg::alu_result_t alu_result
);

  import ecpu_pkg::*;

  logic [DWIDTH:0] sum;
  data_t           b_eff;
  logic            cin;
  // operation code is one of the defined ones
  logic            known;

  // shared adder, sub is a + ~b + 1
  always_comb
  begin
    b_eff = (alu_req.s == ALU_SUB) ? ~alu_req.b : alu_req.b;
    cin   = (alu_req.s == ALU_SUB);
    sum   = {1'b0, alu_req.a} + {1'b0, b_eff} + {{DWIDTH{1'b0}}, cin};
  end

  always_comb
  begin
    alu_result = '0;
    known      = 1'b1;
    case (alu_req.s)
      ALU_ADD, ALU_SUB:
      begin
        alu_result.y = sum[DWIDTH-1:0];
        alu_result.c = sum[DWIDTH];
        alu_result.v = (alu_req.a[DWIDTH-1] == b_eff[DWIDTH-1]) &&
                       (sum[DWIDTH-1] != alu_req.a[DWIDTH-1]);
      end
      ALU_AND:
        alu_result.y = alu_req.a & alu_req.b;
      ALU_OR:
        alu_result.y = alu_req.a | alu_req.b;
      ALU_XOR:
        alu_result.y = alu_req.a ^ alu_req.b;
      ALU_SHL:
        alu_result.y = {alu_req.a[DWIDTH-2:0], 1'b0};
      ALU_SHR:
        alu_result.y = {1'b0, alu_req.a[DWIDTH-1:1]};
      ALU_PASSA:
        alu_result.y = alu_req.a;
      default:
        known = 1'b0;
    endcase
    // unused codes report no flags at all, not even zero
    alu_result.z = known && (alu_result.y == '0);
  end

endmodule

// ==== ecpu_core/ecpu_core_controller.sv ====
`timescale 1ns/1ns

module ecpu_core_controller (
  input  logic                  CLK,
  input  logic                  RESET_N,
  input  logic                  start,
  input  logic                  load_en,
  output logic                  rom_rd,
  output ecpu_pkg::addr_t       rom_addr,
  input  ecpu_pkg::data_t       rom_data,
  output ecpu_pkg::alu_req_t    alu_req,
  input  ecpu_pkg::alu_result_t alu_result,
  output ecpu_pkg::alu_result_t result,
  output logic                  result_valid,
  output ecpu_pkg::acc_src_t    acc_src,
  output logic                  halted
);

  import ecpu_pkg::*;

  localparam addr_t LAST_ADDR = addr_t'(ROM_DEPTH - 1);

  ctrl_state_t state;
  ctrl_state_t state_next;

  addr_t       pc;
  logic [1:0]  opnd_cnt;
  // the word at LAST_ADDR has been fetched, nothing follows it
  logic        last_word;

  alu_req_t    opnd;

  ////////////////////
  // next state
  ////////////////////

  always_comb
  begin
    state_next = state;
    rom_rd     = 1'b0;
    case (state)
      IDLE:
      begin
        if (start && !load_en)
          state_next = INSTR_FETCH;
      end
      INSTR_FETCH:
      begin
        rom_rd     = 1'b1;
        state_next = INSTR_DECODE;
      end
      INSTR_DECODE:
      begin
        if ((rom_data == OP_HALT) || last_word)
          state_next = HALT_CPU;
        else if (rom_data == OP_ALU)
          state_next = OPERAND_FETCH;
        else
          state_next = INSTR_FETCH;
      end
      OPERAND_FETCH:
      begin
        // counts 0..2 issue reads, 1..3 take the returned word
        if (opnd_cnt == 2'd3)
          state_next = EXECUTE;
        else if (last_word)
          state_next = HALT_CPU;
        else
          rom_rd = 1'b1;
      end
      EXECUTE:
      begin
        if (last_word)
          state_next = HALT_CPU;
        else
          state_next = INSTR_FETCH;
      end
      HALT_CPU:
      begin
        state_next = HALT_CPU;
      end
      default:
      begin
        state_next = IDLE;
      end
    endcase
  end

  assign rom_addr = pc;
  assign alu_req  = opnd;
  assign halted   = (state == HALT_CPU);

  ////////////////////
  // control registers
  ////////////////////

  always_ff @(posedge CLK)
  begin
    if (!RESET_N)
    begin
      state        <= IDLE;
      pc           <= '0;
      opnd_cnt     <= '0;
      last_word    <= 1'b0;
      result_valid <= 1'b0;
      acc_src      <= ROM_OUT;
    end
    else
    begin
      state        <= state_next;
      result_valid <= (state == EXECUTE);
      if (rom_rd)
      begin
        pc <= pc + 1'b1;
        if (pc == LAST_ADDR)
          last_word <= 1'b1;
      end
      if (state == INSTR_DECODE)
        opnd_cnt <= '0;
      else if (state == OPERAND_FETCH)
        opnd_cnt <= opnd_cnt + 1'b1;
      if (state == EXECUTE)
        acc_src <= ALU_OUT;
    end
  end

  ////////////////////
  // operands and accumulator
  ////////////////////

  always_ff @(posedge CLK)
  begin
    if (state == OPERAND_FETCH)
    begin
      case (opnd_cnt)
        2'd1: opnd.a <= rom_data;
        2'd2: opnd.b <= rom_data;
        2'd3: opnd.s <= alu_op_t'(rom_data[OPWIDTH-1:0]);
        default: ;
      endcase
    end
    if (state == EXECUTE)
      result <= alu_result;
  end

endmodule

// ==== project.f ====
common/ecpu_pkg.sv
ecpu_core/ecpu_alu.sv
ecpu_core/ecpu_core_controller.sv
design/ecpu_rom.sv
design/ecpu_top.sv
dv/ecpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ecpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module ecpu_tb -f project.f -o ecpu_sim

# exit status is nonzero when the testbench stops with $fatal
./obj_dir/ecpu_sim
